//--- rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    // primary opcodes, inst[31:26]
    localparam logic [5:0]
        OPC_SPECIAL = 6'h00,
        OPC_REGIMM  = 6'h01,
        OPC_J       = 6'h02,
        OPC_JAL     = 6'h03,
        OPC_BEQ     = 6'h04,
        OPC_BNE     = 6'h05,
        OPC_BLEZ    = 6'h06,
        OPC_BGTZ    = 6'h07,
        OPC_ADDI    = 6'h08,
        OPC_ADDIU   = 6'h09,
        OPC_SLTI    = 6'h0a,
        OPC_SLTIU   = 6'h0b,
        OPC_ANDI    = 6'h0c,
        OPC_ORI     = 6'h0d,
        OPC_XORI    = 6'h0e,
        OPC_LUI     = 6'h0f,
        OPC_COP0    = 6'h10,
        OPC_LB      = 6'h20,
        OPC_LH      = 6'h21,
        OPC_LWL     = 6'h22,
        OPC_LW      = 6'h23,
        OPC_LBU     = 6'h24,
        OPC_LHU     = 6'h25,
        OPC_LWR     = 6'h26,
        OPC_SB      = 6'h28,
        OPC_SH      = 6'h29,
        OPC_SWL     = 6'h2a,
        OPC_SW      = 6'h2b,
        OPC_SWR     = 6'h2e,
        OPC_CACHE   = 6'h2f,
        OPC_PREF    = 6'h33;

    // REGIMM, selected by rt
    localparam logic [4:0]
        RT_BLTZ   = 5'h00,
        RT_BGEZ   = 5'h01,
        RT_BLTZAL = 5'h10,
        RT_BGEZAL = 5'h11;

    // SPECIAL funct codes
    localparam logic [5:0]
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_SRA     = 6'h03,
        FN_JR      = 6'h08,
        FN_JALR    = 6'h09,
        FN_SYSCALL = 6'h0c,
        FN_BREAK   = 6'h0d,
        FN_MFHI    = 6'h10,
        FN_MTHI    = 6'h11,
        FN_MFLO    = 6'h12,
        FN_MTLO    = 6'h13,
        FN_ADD     = 6'h20,
        FN_ADDU    = 6'h21,
        FN_SUB     = 6'h22,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a,
        FN_SLTU    = 6'h2b;

    // COP0, rs selects move or CO group
    localparam logic [4:0]
        RS_MFC0 = 5'h00,
        RS_MTC0 = 5'h04;

    localparam logic [5:0]
        FN_TLBWI = 6'h02,
        FN_TLBP  = 6'h08,
        FN_ERET  = 6'h18,
        FN_WAIT  = 6'h20;

    typedef enum logic [7:0] {
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_ADD, OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_JR, OP_JALR, OP_J, OP_JAL,
        OP_SYSCALL, OP_BREAK,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_MFC0, OP_MTC0, OP_ERET, OP_WAIT, OP_TLBWI, OP_TLBP,
        OP_LB, OP_LH, OP_LW, OP_LWL, OP_LWR,
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR,
        OP_CACHE, OP_PREF,
        OP_INVALID = 8'hff // kept away from the reset value of dec.op
    } op_e;

endpackage

//--- rtl/decode_pkg.sv
package decode_pkg;

    typedef enum logic [1:0] {
        EXT_SIGN,
        EXT_ZERO,
        EXT_UPPER,
        EXT_BRANCH // sign extend, then << 2
    } ext_e;

    // overlay on the 32-bit instruction word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } inst_fields_t;

    typedef struct packed {
        mips_isa_pkg::op_e op;
        logic [4:0]        rs;
        logic [4:0]        rt;
        logic [4:0]        rd;
        logic [4:0]        shamt;
        logic [31:0]       imm;
        logic [25:0]       target;
        logic              flag_unsigned;
        logic              invalid;
    } decoded_t;

endpackage

//--- rtl/id_i.sv
`timescale 1ns/100ps

module id_i (
    input  decode_pkg::inst_fields_t fields,
    output mips_isa_pkg::op_e        op,
    output logic                     flag_unsigned,
    output decode_pkg::ext_e         ext_kind
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    assign flag_unsigned = (fields.opcode == OPC_ADDIU) || (fields.opcode == OPC_SLTIU) ||
                           (fields.opcode == OPC_LBU) || (fields.opcode == OPC_LHU);

    always_comb begin
        case (fields.opcode)
            OPC_ANDI, OPC_ORI, OPC_XORI: ext_kind = EXT_ZERO;
            OPC_LUI:                     ext_kind = EXT_UPPER;
            OPC_REGIMM, OPC_BEQ, OPC_BNE,
            OPC_BLEZ, OPC_BGTZ:          ext_kind = EXT_BRANCH;
            default:                     ext_kind = EXT_SIGN;
        endcase
    end

    always_comb begin
        case (fields.opcode)
            OPC_REGIMM: begin
                case (fields.rt)
                    RT_BLTZ:   op = OP_BLTZ;
                    RT_BGEZ:   op = OP_BGEZ;
                    RT_BLTZAL: op = OP_BLTZAL;
                    RT_BGEZAL: op = OP_BGEZAL;
                    default:   op = OP_INVALID;
                endcase
            end
            OPC_BEQ:              op = OP_BEQ;
            OPC_BNE:              op = OP_BNE;
            OPC_BLEZ:             op = (fields.rt == 5'h0) ? OP_BLEZ : OP_INVALID;
            OPC_BGTZ:             op = (fields.rt == 5'h0) ? OP_BGTZ : OP_INVALID;
            OPC_ADDI, OPC_ADDIU:  op = OP_ADD; // unsigned form via flag
            OPC_SLTI, OPC_SLTIU:  op = OP_SLT;
            OPC_ANDI:             op = OP_AND;
            OPC_ORI:              op = OP_OR;
            OPC_XORI:             op = OP_XOR;
            OPC_LUI:              op = (fields.rs == 5'h0) ? OP_LU : OP_INVALID;
            OPC_COP0: begin
                if (fields.rs == RS_MFC0) begin
                    op = OP_MFC0;
                end else if (fields.rs == RS_MTC0) begin
                    op = OP_MTC0;
                end else if (fields.rs[4]) begin // CO bit
                    case (fields.funct)
                        FN_ERET:  op = OP_ERET;
                        FN_WAIT:  op = OP_WAIT;
                        FN_TLBWI: op = OP_TLBWI;
                        FN_TLBP:  op = OP_TLBP;
                        default:  op = OP_INVALID;
                    endcase
                end else begin
                    op = OP_INVALID;
                end
            end
            OPC_LB, OPC_LBU:      op = OP_LB;
            OPC_LH, OPC_LHU:      op = OP_LH;
            OPC_LW:               op = OP_LW;
            OPC_LWL:              op = OP_LWL;
            OPC_LWR:              op = OP_LWR;
            OPC_SB:               op = OP_SB;
            OPC_SH:               op = OP_SH;
            OPC_SW:               op = OP_SW;
            OPC_SWL:              op = OP_SWL;
            OPC_SWR:              op = OP_SWR;
            OPC_CACHE:            op = OP_CACHE;
            OPC_PREF:             op = OP_PREF;
            // no LL/SC
            default:              op = OP_INVALID;
        endcase
    end

endmodule

//--- rtl/id_r.sv
`timescale 1ns/100ps

module id_r (
    input  decode_pkg::inst_fields_t fields,
    output mips_isa_pkg::op_e        op,
    output logic                     flag_unsigned
);
    import mips_isa_pkg::*;

    logic rs_zero;

    assign rs_zero = (fields.rs == 5'h0); // shifts by shamt need rs == 0

    // same rule as the I-type side: one op, unsigned form flagged
    assign flag_unsigned = (fields.funct == FN_ADDU) || (fields.funct == FN_SUBU) ||
                           (fields.funct == FN_SLTU);

    always_comb begin
        case (fields.funct)
            FN_SLL:           op = rs_zero ? OP_SLL : OP_INVALID;
            FN_SRL:           op = rs_zero ? OP_SRL : OP_INVALID;
            FN_SRA:           op = rs_zero ? OP_SRA : OP_INVALID;
            FN_JR:            op = OP_JR;
            FN_JALR:          op = OP_JALR;
            FN_SYSCALL:       op = OP_SYSCALL;
            FN_BREAK:         op = OP_BREAK;
            FN_MFHI:          op = OP_MFHI;
            FN_MTHI:          op = OP_MTHI;
            FN_MFLO:          op = OP_MFLO;
            FN_MTLO:          op = OP_MTLO;
            FN_ADD, FN_ADDU:  op = OP_ADD;
            FN_SUB, FN_SUBU:  op = OP_SUBU;
            FN_SLT, FN_SLTU:  op = OP_SLT;
            FN_AND:           op = OP_AND;
            FN_OR:            op = OP_OR;
            FN_XOR:           op = OP_XOR;
            FN_NOR:           op = OP_NOR;
            default:          op = OP_INVALID; // variable shifts, mult/div etc
        endcase
    end

endmodule

//--- rtl/imm_ext.sv
`timescale 1ns/100ps

module imm_ext (
    input  logic [15:0]      imm16,
    input  decode_pkg::ext_e ext_kind,
    output logic [31:0]      imm
);
    import decode_pkg::*;

    logic sign;

    assign sign = imm16[15];

    always_comb begin
        case (ext_kind)
            EXT_ZERO:   imm = {16'h0000, imm16};
            EXT_UPPER:  imm = {imm16, 16'h0000};    // lui
            EXT_BRANCH: imm = {{14{sign}}, imm16, 2'b00}; // word offset
            default:    imm = {{16{sign}}, imm16};
        endcase
    end

endmodule

//--- rtl/decode_ctrl.sv
`timescale 1ns/100ps

module decode_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     inst_valid,
    input  logic [31:0]              inst,
    input  mips_isa_pkg::op_e        op_i,
    input  logic                     flag_i,
    input  decode_pkg::ext_e         ext_i,
    input  mips_isa_pkg::op_e        op_r,
    input  logic                     flag_r,
    input  logic [31:0]              imm,
    output decode_pkg::inst_fields_t fields,
    output logic [15:0]              imm16,
    output decode_pkg::ext_e         ext_kind,
    output logic                     dec_valid,
    output decode_pkg::decoded_t     dec
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    typedef enum logic [1:0] {
        CLS_I,
        CLS_R,
        CLS_J
    } cls_e;

    cls_e     cls;
    op_e      op_sel;
    logic     flag_sel;
    decoded_t dec_d;

    assign fields = inst;
    assign imm16  = inst[15:0];

    // only place the primary opcode is classified
    always_comb begin
        case (fields.opcode)
            OPC_SPECIAL:    cls = CLS_R;
            OPC_J, OPC_JAL: cls = CLS_J;
            default:        cls = CLS_I;
        endcase
    end

    assign ext_kind = (cls == CLS_I) ? ext_i : EXT_SIGN;

    always_comb begin
        case (cls)
            CLS_R: begin
                op_sel   = op_r;
                flag_sel = flag_r;
            end
            CLS_J: begin
                op_sel   = (fields.opcode == OPC_JAL) ? OP_JAL : OP_J;
                flag_sel = 1'b0;
            end
            default: begin
                op_sel   = op_i;
                flag_sel = flag_i;
            end
        endcase
    end

    always_comb begin
        dec_d.op            = op_sel;
        dec_d.rs            = fields.rs;
        dec_d.rt            = fields.rt;
        dec_d.rd            = fields.rd;
        dec_d.shamt         = fields.shamt;
        dec_d.imm           = imm;
        dec_d.target        = inst[25:0];
        dec_d.flag_unsigned = flag_sel;
        dec_d.invalid       = (op_sel == OP_INVALID);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= inst_valid; // single cycle strobe
            if (inst_valid) begin
                dec <= dec_d;   // held between strobes
            end
        end
    end

endmodule

//--- rtl/mips_decode_top.sv
`timescale 1ns/100ps

module mips_decode_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 inst_valid,
    input  logic [31:0]          inst,
    output logic                 dec_valid,
    output decode_pkg::decoded_t dec
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    inst_fields_t fields;
    op_e          op_i;
    op_e          op_r;
    logic         flag_i;
    logic         flag_r;
    ext_e         ext_i;
    ext_e         ext_kind;
    logic [15:0]  imm16;
    logic [31:0]  imm;

    decode_ctrl decode_ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .op_i       (op_i),
        .flag_i     (flag_i),
        .ext_i      (ext_i),
        .op_r       (op_r),
        .flag_r     (flag_r),
        .imm        (imm),
        .fields     (fields),
        .imm16      (imm16),
        .ext_kind   (ext_kind),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    id_i id_i_i (
        .fields        (fields),
        .op            (op_i),
        .flag_unsigned (flag_i),
        .ext_kind      (ext_i)
    );

    id_r id_r_i (
        .fields        (fields),
        .op            (op_r),
        .flag_unsigned (flag_r)
    );

    imm_ext imm_ext_i (
        .imm16    (imm16),
        .ext_kind (ext_kind),
        .imm      (imm)
    );

endmodule

//--- tb/mips_decode_assert.sv
`timescale 1ns/100ps

module mips_decode_assert (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 inst_valid,
    input  logic                 dec_valid,
    input  decode_pkg::decoded_t dec
);
    import mips_isa_pkg::*;

    int fail_count = 0; // read by the testbench at the end

    a_reset_state: assert property (@(posedge clk) !arst_n |-> (!dec_valid && dec == '0))
        else begin
            fail_count++;
            $error("dec_valid or dec not cleared while in reset");
        end

    // one cycle latency
    a_strobe_to_valid: assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid |=> dec_valid)
        else begin
            fail_count++;
            $error("dec_valid missing one cycle after inst_valid");
        end

    a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
        !inst_valid |=> !dec_valid)
        else begin
            fail_count++;
            $error("dec_valid raised without a preceding inst_valid");
        end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !inst_valid |=> $stable(dec))
        else begin
            fail_count++;
            $error("dec changed without a strobe");
        end

    a_invalid_flag: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid |-> (dec.invalid == (dec.op == OP_INVALID)))
        else begin
            fail_count++;
            $error("dec.invalid does not match dec.op == OP_INVALID");
        end

endmodule

bind mips_decode_top mips_decode_assert mips_decode_assert_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .dec_valid  (dec_valid),
    .dec        (dec)
);

//--- tb/tb_mips_decode.sv
`timescale 1ns/100ps

module tb_mips_decode;
    import mips_isa_pkg::*;
    import decode_pkg::*;

    localparam int N_ITYPE  = 64 + 32 + 6 + 32 + 64;
    localparam int N_RTYPE  = 128 + 16;
    localparam int N_IMM    = 128;
    localparam int N_RANDOM = 200;
    localparam int N_STIM   = N_ITYPE + N_RTYPE + N_IMM + N_RANDOM;
    localparam int CYCLE_LIMIT = 2 * N_STIM + 50; // at most one idle cycle per word

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        dec_valid;
    decoded_t    dec;

    decoded_t    exp_q[$];
    logic [31:0] rng_state;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          mark_checks = 0;
    int          mark_errors = 0;
    int          total_fail;

    mips_decode_top mips_decode_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // expected decode, built from the encoding table
    function automatic decoded_t ref_decode(input logic [31:0] w);
        decoded_t   d;
        ext_e       ext;
        logic [5:0] opc;
        logic [5:0] fn;
        logic [4:0] rs;
        logic [4:0] rt;
        opc = w[31:26];
        rs  = w[25:21];
        rt  = w[20:16];
        fn  = w[5:0];
        d = '0;
        ext = EXT_SIGN;
        d.op = OP_INVALID;
        d.rs = rs;
        d.rt = rt;
        d.rd = w[15:11];
        d.shamt = w[10:6];
        d.target = w[25:0];
        if (opc == OPC_SPECIAL) begin
            d.flag_unsigned = (fn == FN_ADDU) || (fn == FN_SUBU) || (fn == FN_SLTU);
            case (fn)
                FN_SLL: if (rs == 5'd0) d.op = OP_SLL;
                FN_SRL: if (rs == 5'd0) d.op = OP_SRL;
                FN_SRA: if (rs == 5'd0) d.op = OP_SRA;
                FN_JR: d.op = OP_JR;
                FN_JALR: d.op = OP_JALR;
                FN_SYSCALL: d.op = OP_SYSCALL;
                FN_BREAK: d.op = OP_BREAK;
                FN_MFHI: d.op = OP_MFHI;
                FN_MTHI: d.op = OP_MTHI;
                FN_MFLO: d.op = OP_MFLO;
                FN_MTLO: d.op = OP_MTLO;
                FN_ADD, FN_ADDU: d.op = OP_ADD;
                FN_SUB, FN_SUBU: d.op = OP_SUBU;
                FN_SLT, FN_SLTU: d.op = OP_SLT;
                FN_AND: d.op = OP_AND;
                FN_OR: d.op = OP_OR;
                FN_XOR: d.op = OP_XOR;
                FN_NOR: d.op = OP_NOR;
                default: d.op = OP_INVALID;
            endcase
        end else if (opc == OPC_J) begin
            d.op = OP_J;
        end else if (opc == OPC_JAL) begin
            d.op = OP_JAL;
        end else begin
            d.flag_unsigned = (opc == OPC_ADDIU) || (opc == OPC_SLTIU) ||
                              (opc == OPC_LBU) || (opc == OPC_LHU);
            case (opc)
                OPC_ANDI, OPC_ORI, OPC_XORI: ext = EXT_ZERO;
                OPC_LUI: ext = EXT_UPPER;
                OPC_REGIMM, OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ: ext = EXT_BRANCH;
                default: ext = EXT_SIGN;
            endcase
            case (opc)
                OPC_REGIMM: begin
                    if (rt == RT_BLTZ) d.op = OP_BLTZ;
                    if (rt == RT_BGEZ) d.op = OP_BGEZ;
                    if (rt == RT_BLTZAL) d.op = OP_BLTZAL;
                    if (rt == RT_BGEZAL) d.op = OP_BGEZAL;
                end
                OPC_BEQ: d.op = OP_BEQ;
                OPC_BNE: d.op = OP_BNE;
                OPC_BLEZ: if (rt == 5'd0) d.op = OP_BLEZ;
                OPC_BGTZ: if (rt == 5'd0) d.op = OP_BGTZ;
                OPC_ADDI, OPC_ADDIU: d.op = OP_ADD;
                OPC_SLTI, OPC_SLTIU: d.op = OP_SLT;
                OPC_ANDI: d.op = OP_AND;
                OPC_ORI: d.op = OP_OR;
                OPC_XORI: d.op = OP_XOR;
                OPC_LUI: if (rs == 5'd0) d.op = OP_LU;
                OPC_COP0: begin
                    if (rs == RS_MFC0) d.op = OP_MFC0;
                    else if (rs == RS_MTC0) d.op = OP_MTC0;
                    else if (rs[4] && fn == FN_ERET) d.op = OP_ERET;
                    else if (rs[4] && fn == FN_WAIT) d.op = OP_WAIT;
                    else if (rs[4] && fn == FN_TLBWI) d.op = OP_TLBWI;
                    else if (rs[4] && fn == FN_TLBP) d.op = OP_TLBP;
                end
                OPC_LB, OPC_LBU: d.op = OP_LB;
                OPC_LH, OPC_LHU: d.op = OP_LH;
                OPC_LW: d.op = OP_LW;
                OPC_LWL: d.op = OP_LWL;
                OPC_LWR: d.op = OP_LWR;
                OPC_SB: d.op = OP_SB;
                OPC_SH: d.op = OP_SH;
                OPC_SW: d.op = OP_SW;
                OPC_SWL: d.op = OP_SWL;
                OPC_SWR: d.op = OP_SWR;
                OPC_CACHE: d.op = OP_CACHE;
                OPC_PREF: d.op = OP_PREF;
                default: d.op = OP_INVALID;
            endcase
        end
        case (ext)
            EXT_ZERO: d.imm = {16'h0000, w[15:0]};
            EXT_UPPER: d.imm = {w[15:0], 16'h0000};
            EXT_BRANCH: d.imm = {{16{w[15]}}, w[15:0]} << 2;
            default: d.imm = {{16{w[15]}}, w[15:0]};
        endcase
        d.invalid = (d.op == OP_INVALID);
        return d;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            $display("[ERROR] %s expected %h got %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    // random idle cycle before some words, garbage on inst while idle
    task automatic send(input logic [31:0] w);
        logic [31:0] r;
        r = next_rand();
        if (r[31]) begin
            @(negedge clk);
            inst_valid = 1'b0;
            inst = r;
        end
        @(negedge clk);
        inst_valid = 1'b1;
        inst = w;
        exp_q.push_back(ref_decode(w));
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        inst_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // results are stable a half cycle after the edge that registered them
    always @(negedge clk) begin
        decoded_t e;
        if (arst_n && dec_valid) begin
            if (exp_q.size() == 0) begin
                $display("dec_valid seen with no instruction outstanding");
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_field("dec.op", e.op, dec.op);
                check_field("dec.flag_unsigned", e.flag_unsigned, dec.flag_unsigned);
                check_field("dec.imm", e.imm, dec.imm);
                check_field("dec.target", e.target, dec.target);
                check_field("dec.rs", e.rs, dec.rs);
                check_field("dec.rt", e.rt, dec.rt);
                check_field("dec.rd", e.rd, dec.rd);
                check_field("dec.shamt", e.shamt, dec.shamt);
                check_field("dec.invalid", e.invalid, dec.invalid);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [5:0]  imm_opcs [8];
        imm_opcs = '{OPC_ADDI, OPC_SLTIU, OPC_ANDI, OPC_ORI,
                     OPC_LUI, OPC_BEQ, OPC_BNE, OPC_LW};
        rng_state = 32'hd94d;
        clk = 1'b0;
        arst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            send({i[5:0], r[25:0]});
        end
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            send({OPC_REGIMM, r[25:21], i[4:0], r[15:0]});
        end
        send({OPC_BLEZ, 5'd3, 5'd0, 16'h8001});
        send({OPC_BLEZ, 5'd3, 5'd7, 16'h0010});
        send({OPC_BGTZ, 5'd4, 5'd0, 16'h7ffc});
        send({OPC_BGTZ, 5'd4, 5'd1, 16'hfff0});
        send({OPC_LUI, 5'd0, 5'd9, 16'hbeef});
        send({OPC_LUI, 5'd2, 5'd9, 16'hbeef}); // rs must be zero
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            send({OPC_COP0, i[4:0], r[20:0]});
        end
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            send({OPC_COP0, 5'h10, r[20:6], i[5:0]});
        end
        end_test("i-type table");

        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            send({OPC_SPECIAL, 5'd0, r[20:6], i[5:0]});
        end
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            send({OPC_SPECIAL, r[25:21] | 5'd1, r[20:6], i[5:0]});
        end
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            send({OPC_J, r[25:0]});
            send({OPC_JAL, r[25:0] ^ 26'h2aaaaaa});
        end
        end_test("r-type and jumps");

        for (int i = 0; i < N_IMM; i++) begin
            r = next_rand();
            send({imm_opcs[i % 8], 5'd0, r[20:16], i[3], r[14:0]}); // sign bit alternates
        end
        end_test("immediate extension");

        for (int i = 0; i < N_RANDOM; i++) begin
            send(next_rand());
        end
        end_test("field pass-through");

        total_fail = errors + mips_decode_top_i.mips_decode_assert_i.fail_count;
        $display("test reset and strobe timing: %0d assertion failures",
                 mips_decode_top_i.mips_decode_assert_i.fail_count);
        $display("checks passed %0d, failed %0d", checks - errors, total_fail);
        if (total_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- mips_decode.f
rtl/mips_isa_pkg.sv
rtl/decode_pkg.sv
rtl/id_i.sv
rtl/id_r.sv
rtl/imm_ext.sv
rtl/decode_ctrl.sv
rtl/mips_decode_top.sv
tb/mips_decode_assert.sv
tb/tb_mips_decode.sv

//--- Bender.yml
package:
  name: mips_decode

sources:
  - files:
      - rtl/mips_isa_pkg.sv
      - rtl/decode_pkg.sv
      - rtl/id_i.sv
      - rtl/id_r.sv
      - rtl/imm_ext.sv
      - rtl/decode_ctrl.sv
      - rtl/mips_decode_top.sv
  - target: test
    files:
      - tb/mips_decode_assert.sv
      - tb/tb_mips_decode.sv
